//--- common/gmiiTrafficPkg.sv
// GMII traffic package with field widths, framing constants, LFSR step and controller states
package gmiiTrafficPkg;

	typedef logic [7:0]  octetT;     // One GMII data octet
	typedef logic [15:0] frameLenT;  // Octets incl. preamble and SFD
	typedef logic [7:0]  frameCntT;
	typedef logic [5:0]  ifgLenT;    // Idle cycles between frames
	typedef logic [7:0]  lfsrT;

	localparam octetT    PreambleOctet = 8'h55;
	localparam octetT    SfdOctet      = 8'hD5;
	localparam frameLenT PreambleLen   = 16'd7;
	localparam frameLenT LenFieldPos   = 16'd8;  // Low byte here, high byte next, payload after
	localparam frameLenT MinFrameLen   = 16'd64;
	localparam lfsrT     LfsrTaps      = 8'hB8;  // x^8+x^6+x^5+x^4+1, right-shifting Galois form

	typedef enum logic [1:0] {
		Idle,
		Send,
		Gap
	} ctrlStateT;

	// One Galois step; the all-zero state would lock up so it restarts at 1
	function automatic lfsrT lfsrNext(input lfsrT s);
		lfsrT n;
		if (s == '0)
			n = 8'h01;
		else
			n = (s >> 1) ^ (s[0] ? LfsrTaps : '0);
		return n;
	endfunction

	// Octet expected at a given frame position
	function automatic octetT frameOctet(input frameLenT idx, input frameLenT len,
		input lfsrT lfsr);
		octetT o;
		if (idx < PreambleLen)
			o = PreambleOctet;
		else if (idx == PreambleLen)
			o = SfdOctet;
		else if (idx == LenFieldPos)
			o = len[7:0];
		else if (idx == LenFieldPos + 1'b1)
			o = len[15:8];
		else
			o = lfsr;  // Payload
		return o;
	endfunction

endpackage

//--- common/frameCfgIf.sv
// Per-frame control link between the burst controller and the transmit and receive datapaths
`timescale 1ns/1ps

interface frameCfgIf;

	gmiiTrafficPkg::frameLenT frameLen;  // Held for the whole burst
	gmiiTrafficPkg::lfsrT     seed;
	logic                     frameStartStb;
	logic                     frameEndStb;  // Coincides with the last transmitted octet

	modport ctrl (
		output frameLen,
		output seed,
		output frameStartStb,
		input  frameEndStb
	);

	modport gen (
		input  frameLen,
		input  seed,
		input  frameStartStb,
		output frameEndStb
	);

	// Checker only needs to rebuild the expected frame
	modport chk (
		input  frameLen,
		input  seed
	);

endinterface

//--- src/pktCtrl.sv
// Burst controller that sequences frames and inter-frame gaps and flags the end of a burst
`timescale 1ns/1ps

module pktCtrl #(
	parameter int MinIfg = 12  // At least 3 and below 64
) (
	input  logic                     w_u0GMIIClk,
	input  logic                     i_reset,
	input  logic                     i_startStb,
	input  gmiiTrafficPkg::frameLenT i_frameLen,
	input  gmiiTrafficPkg::frameCntT i_frameCnt,
	input  gmiiTrafficPkg::ifgLenT   i_ifgLen,
	input  gmiiTrafficPkg::lfsrT     i_seed,
	output logic                     o_busy,
	output logic                     o_doneStb,
	frameCfgIf.ctrl                  cfg
);

	gmiiTrafficPkg::ctrlStateT state;
	gmiiTrafficPkg::frameCntT  framesLeft;  // Frames still to send after the current one
	gmiiTrafficPkg::ifgLenT    effGap;
	gmiiTrafficPkg::ifgLenT    gapCnt;
	gmiiTrafficPkg::ifgLenT    minGap;
	logic                      startOk;

	assign minGap  = gmiiTrafficPkg::ifgLenT'(MinIfg);
	assign o_busy  = (state != gmiiTrafficPkg::Idle);
	assign startOk = (state == gmiiTrafficPkg::Idle) && i_startStb;  // Strobes while busy dropped

	// Burst settings stay put until the next accepted strobe
	always_ff @(posedge w_u0GMIIClk)
	begin
		if (startOk)
		begin
			cfg.frameLen <= i_frameLen;
			cfg.seed     <= i_seed;
			effGap       <= (i_ifgLen > minGap) ? i_ifgLen : minGap;
		end
	end

	// Gap count is shortened by the two-cycle start latency of the generator
	always_ff @(posedge w_u0GMIIClk)
	begin
		if (i_reset)
		begin
			state             <= gmiiTrafficPkg::Idle;
			framesLeft        <= '0;
			gapCnt            <= '0;
			cfg.frameStartStb <= 1'b0;
			o_doneStb         <= 1'b0;
		end
		else
		begin
			cfg.frameStartStb <= 1'b0;
			o_doneStb         <= 1'b0;
			case (state)
				gmiiTrafficPkg::Idle:
				begin
					if (startOk)
					begin
						// Zero count means a single frame
						framesLeft        <= (i_frameCnt == '0) ? '0 : i_frameCnt - 1'b1;
						cfg.frameStartStb <= 1'b1;
						state             <= gmiiTrafficPkg::Send;
					end
				end
				gmiiTrafficPkg::Send:
				begin
					if (cfg.frameEndStb)
					begin
						state  <= gmiiTrafficPkg::Gap;
						gapCnt <= (framesLeft != '0) ? effGap - gmiiTrafficPkg::ifgLenT'(3)
							: effGap - gmiiTrafficPkg::ifgLenT'(1);
					end
				end
				gmiiTrafficPkg::Gap:
				begin
					if (gapCnt != '0)
						gapCnt <= gapCnt - 1'b1;
					else if (framesLeft != '0)
					begin
						framesLeft        <= framesLeft - 1'b1;
						cfg.frameStartStb <= 1'b1;
						state             <= gmiiTrafficPkg::Send;
					end
					else
					begin
						o_doneStb <= 1'b1;  // Busy drops in the same cycle
						state     <= gmiiTrafficPkg::Idle;
					end
				end
				default: state <= gmiiTrafficPkg::Idle;
			endcase
		end
	end

endmodule

//--- frameGen/frameGen.sv
// Transmit frame generator emitting preamble, SFD, length field and LFSR payload on GMII
`timescale 1ns/1ps

module frameGen (
	input  logic                  w_u0GMIIClk,
	input  logic                  i_reset,
	frameCfgIf.gen                cfg,
	output gmiiTrafficPkg::octetT o_txD,
	output logic                  o_txEn
);

	logic                     running;
	gmiiTrafficPkg::frameLenT idx;  // Position of the octet being built
	gmiiTrafficPkg::lfsrT     lfsr;
	gmiiTrafficPkg::octetT    nextOctet;
	logic                     lastOctet;
	logic                     inPayload;

	assign lastOctet = (idx == cfg.frameLen - 1'b1);
	assign inPayload = (idx > gmiiTrafficPkg::LenFieldPos + 1'b1);
	assign nextOctet = gmiiTrafficPkg::frameOctet(idx, cfg.frameLen, lfsr);

	// Octet sequencer
	always_ff @(posedge w_u0GMIIClk)
	begin
		if (i_reset)
		begin
			running <= 1'b0;
			idx     <= '0;
		end
		else if (cfg.frameStartStb)
		begin
			running <= 1'b1;
			idx     <= '0;
		end
		else if (running)
		begin
			idx <= idx + 1'b1;
			if (lastOctet)
				running <= 1'b0;
		end
	end

	// Payload generator, steps once per payload octet sent
	always_ff @(posedge w_u0GMIIClk)
	begin
		if (cfg.frameStartStb)
			lfsr <= cfg.seed;
		else if (running && inPayload)
			lfsr <= gmiiTrafficPkg::lfsrNext(lfsr);
	end

	// Registered GMII outputs, end strobe aligned to the final octet
	always_ff @(posedge w_u0GMIIClk)
	begin
		if (i_reset)
		begin
			o_txEn          <= 1'b0;
			o_txD           <= '0;
			cfg.frameEndStb <= 1'b0;
		end
		else
		begin
			o_txEn          <= running;
			o_txD           <= running ? nextOctet : '0;  // Idle data kept at zero
			cfg.frameEndStb <= running && lastOctet;
		end
	end

endmodule

//--- frameCheck/frameCheck.sv
// Receive frame checker comparing GMII octets with the expected frame and counting results
`timescale 1ns/1ps

module frameCheck (
	input  logic                     w_u0GMIIClk,
	input  logic                     i_reset,
	input  gmiiTrafficPkg::octetT    i_rxD,
	input  logic                     i_rxDv,
	input  logic                     i_rxEr,
	frameCfgIf.chk                   cfg,
	output gmiiTrafficPkg::frameCntT o_goodFrames,
	output gmiiTrafficPkg::frameCntT o_badFrames
);

	logic                     inFrame;  // rxDv of the previous cycle
	gmiiTrafficPkg::frameLenT cnt;      // Octets received so far
	gmiiTrafficPkg::frameLenT curIdx;
	gmiiTrafficPkg::frameLenT rxLen;    // Length field as received
	gmiiTrafficPkg::lfsrT     lfsr;
	gmiiTrafficPkg::octetT    expOctet;
	logic                     mismatch;
	logic                     errSeen;
	logic                     frameBad;
	logic                     frameDone;

	assign curIdx    = inFrame ? cnt : '0;  // First octet of a frame is index 0
	assign expOctet  = gmiiTrafficPkg::frameOctet(curIdx, cfg.frameLen, lfsr);
	assign mismatch  = i_rxDv && (i_rxD != expOctet);
	assign frameDone = inFrame && !i_rxDv;

	// Runts and length disagreements count as bad too
	assign frameBad = errSeen || (cnt != rxLen) || (cnt < gmiiTrafficPkg::MinFrameLen);

	always_ff @(posedge w_u0GMIIClk)
	begin
		if (i_rxDv && !inFrame)
			lfsr <= cfg.seed;
		else if (i_rxDv && curIdx > gmiiTrafficPkg::LenFieldPos + 1'b1)
			lfsr <= gmiiTrafficPkg::lfsrNext(lfsr);

		if (i_rxDv && curIdx == gmiiTrafficPkg::LenFieldPos)
			rxLen[7:0] <= i_rxD;
		if (i_rxDv && curIdx == gmiiTrafficPkg::LenFieldPos + 1'b1)
			rxLen[15:8] <= i_rxD;
	end

	always_ff @(posedge w_u0GMIIClk)
	begin
		if (i_reset)
		begin
			inFrame      <= 1'b0;
			cnt          <= '0;
			errSeen      <= 1'b0;
			o_goodFrames <= '0;
			o_badFrames  <= '0;
		end
		else
		begin
			inFrame <= i_rxDv;
			if (i_rxDv)
			begin
				cnt     <= curIdx + 1'b1;
				errSeen <= (inFrame && errSeen) || mismatch || i_rxEr;  // Cleared on a new frame
			end

			// Verdict in the cycle after rxDv drops, counters stick at all ones
			if (frameDone)
			begin
				if (frameBad)
				begin
					if (o_badFrames != '1)
						o_badFrames <= o_badFrames + 1'b1;
				end
				else if (o_goodFrames != '1)
					o_goodFrames <= o_goodFrames + 1'b1;
			end
		end
	end

endmodule

//--- src/gmiiTrafficTop.sv
// GMII traffic generator and checker top level with burst control on plain ports
`timescale 1ns/1ps

module gmiiTrafficTop #(
	parameter int MinIfg = 12
) (
	input  logic                     w_u0GMIIClk,
	input  logic                     i_reset,

	// Burst configuration, sampled with the start strobe
	input  logic                     i_startStb,
	input  gmiiTrafficPkg::frameLenT i_frameLen,
	input  gmiiTrafficPkg::frameCntT i_frameCnt,
	input  gmiiTrafficPkg::ifgLenT   i_ifgLen,
	input  gmiiTrafficPkg::lfsrT     i_seed,

	// GMII transmit
	output gmiiTrafficPkg::octetT    o_txD,
	output logic                     o_txEn,

	// GMII receive
	input  gmiiTrafficPkg::octetT    i_rxD,
	input  logic                     i_rxDv,
	input  logic                     i_rxEr,

	output logic                     o_busy,
	output logic                     o_doneStb,
	output gmiiTrafficPkg::frameCntT o_goodFrames,
	output gmiiTrafficPkg::frameCntT o_badFrames
);

	frameCfgIf frameCfgIf_i ();

	pktCtrl #(
		.MinIfg (MinIfg)
	) pktCtrl_i (
		.w_u0GMIIClk (w_u0GMIIClk),
		.i_reset     (i_reset),
		.i_startStb  (i_startStb),
		.i_frameLen  (i_frameLen),
		.i_frameCnt  (i_frameCnt),
		.i_ifgLen    (i_ifgLen),
		.i_seed      (i_seed),
		.o_busy      (o_busy),
		.o_doneStb   (o_doneStb),
		.cfg         (frameCfgIf_i.ctrl)
	);

	frameGen frameGen_i (
		.w_u0GMIIClk (w_u0GMIIClk),
		.i_reset     (i_reset),
		.cfg         (frameCfgIf_i.gen),
		.o_txD       (o_txD),
		.o_txEn      (o_txEn)
	);

	frameCheck frameCheck_i (
		.w_u0GMIIClk  (w_u0GMIIClk),
		.i_reset      (i_reset),
		.i_rxD        (i_rxD),
		.i_rxDv       (i_rxDv),
		.i_rxEr       (i_rxEr),
		.cfg          (frameCfgIf_i.chk),
		.o_goodFrames (o_goodFrames),
		.o_badFrames  (o_badFrames)
	);

endmodule

//--- dv/gmiiTraffic_assertions.sv
// Bound checks on GMII transmit framing and the per-frame control strobes of the generator
`timescale 1ns/1ps

module gmiiTraffic_assertions (
	input logic                  w_u0GMIIClk,
	input logic                  i_reset,
	input gmiiTrafficPkg::octetT i_txD,
	input logic                  i_txEn,
	input logic                  i_frameStartStb,
	input logic                  i_frameEndStb
);

	int failCount = 0;  // Number of failed checks

	// End strobe marks the last octet, so enable is high now and drops in the next cycle
	endInFrame: assert property (@(posedge w_u0GMIIClk) disable iff (i_reset)
		i_frameEndStb |-> i_txEn ##1 !i_txEn)
	else
	begin
		failCount++;
		$error("Frame end strobe not aligned with the last octet of a frame");
	end

	firstOctet: assert property (@(posedge w_u0GMIIClk) disable iff (i_reset)
		$rose(i_txEn) |-> (i_txD == gmiiTrafficPkg::PreambleOctet))
	else
	begin
		failCount++;
		$error("First octet of a frame is not a preamble octet");
	end

	// New frames only start in a gap
	startInGap: assert property (@(posedge w_u0GMIIClk) disable iff (i_reset)
		i_frameStartStb |-> !i_txEn)
	else
	begin
		failCount++;
		$error("Frame start strobe asserted during a frame");
	end

endmodule

//--- dv/gmiiTrafficTb.sv
// Testbench for the GMII traffic generator with transmit looped back to receive and fault injection
`timescale 1ns/1ps

module gmiiTrafficTb;

	localparam int MinIfg       = 12;
	localparam int PayloadStart = 10;  // After preamble, SFD and length field
	localparam int StartLatency = 3;   // Falling edges from strobe drive to the first octet

	typedef struct {
		string name;
		int    len;
		int    cnt;
		int    ifg;
		int    seed;
		string fault;
		int    faultFrame;
		int    good;
		int    bad;
	} testT;

	logic                     w_u0GMIIClk = 1'b0;
	logic                     i_reset;
	logic                     i_startStb;
	gmiiTrafficPkg::frameLenT i_frameLen;
	gmiiTrafficPkg::frameCntT i_frameCnt;
	gmiiTrafficPkg::ifgLenT   i_ifgLen;
	gmiiTrafficPkg::lfsrT     i_seed;
	gmiiTrafficPkg::octetT    i_rxD = '0;
	logic                     i_rxDv = 1'b0;
	logic                     i_rxEr = 1'b0;
	gmiiTrafficPkg::octetT    o_txD;
	logic                     o_txEn;
	logic                     o_busy;
	logic                     o_doneStb;
	gmiiTrafficPkg::frameCntT o_goodFrames;
	gmiiTrafficPkg::frameCntT o_badFrames;

	testT  tests[$];
	int    errCount = 0;
	string curName = "reset";
	int    curLen = 0;
	int    curGap = 0;
	int    curSeed = 0;
	int    faultKind = 0;  // 0 none, 1 flip, 2 rxer
	int    faultFrame = 0;
	int    faultPos = 0;
	int    framesSeen = 0;
	int    doneSeen = 0;
	int    highRun = 0;
	int    lowRun = 0;
	int    burstFrame = 0;
	int    octetPos = 0;
	logic  prevEn = 1'b0;
	logic  idleGap = 1'b1;  // Busy was low since the last frame ended
	logic  hit;
	int    budget = 0;
	logic  budgetReady = 1'b0;

	gmiiTrafficPkg::octetT expD;
	gmiiTrafficPkg::lfsrT  txLfsr = '0;

	gmiiTrafficTop #(
		.MinIfg (MinIfg)
	) gmiiTrafficTop_i (
		.w_u0GMIIClk  (w_u0GMIIClk),
		.i_reset      (i_reset),
		.i_startStb   (i_startStb),
		.i_frameLen   (i_frameLen),
		.i_frameCnt   (i_frameCnt),
		.i_ifgLen     (i_ifgLen),
		.i_seed       (i_seed),
		.o_txD        (o_txD),
		.o_txEn       (o_txEn),
		.i_rxD        (i_rxD),
		.i_rxDv       (i_rxDv),
		.i_rxEr       (i_rxEr),
		.o_busy       (o_busy),
		.o_doneStb    (o_doneStb),
		.o_goodFrames (o_goodFrames),
		.o_badFrames  (o_badFrames)
	);

	bind frameGen gmiiTraffic_assertions txFramingChk_i (
		.w_u0GMIIClk     (w_u0GMIIClk),
		.i_reset         (i_reset),
		.i_txD           (o_txD),
		.i_txEn          (o_txEn),
		.i_frameStartStb (cfg.frameStartStb),
		.i_frameEndStb   (cfg.frameEndStb)
	);

	always #20 w_u0GMIIClk = ~w_u0GMIIClk;

	task automatic checkValue(input string what, input int expVal, input int actVal);
		assert (actVal == expVal)
		else
		begin
			errCount++;
			$display("Error: test %s, %s expected %0d actual %0d", curName, what, expVal, actVal);
		end
	endtask

	// Galois step for x^8+x^6+x^5+x^4+1 where a zero state restarts at 1
	function automatic gmiiTrafficPkg::lfsrT lfsrStep(input gmiiTrafficPkg::lfsrT s);
		gmiiTrafficPkg::lfsrT n;
		if (s == '0)
			n = 8'h01;
		else
		begin
			n[7]   = s[0];
			n[6]   = s[7];
			n[5]   = s[6] ^ s[0];
			n[4]   = s[5] ^ s[0];
			n[3]   = s[4] ^ s[0];
			n[2:0] = s[3:1];
		end
		return n;
	endfunction

	task automatic loadTests();
		int   fd;
		int   n;
		string line;
		testT t;
		fd = $fopen("dv/gmiiTraffic_tests.txt", "r");
		if (fd == 0)
		begin
			errCount++;
			$display("Could not open the test file dv/gmiiTraffic_tests.txt");
			return;
		end
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 0 && $sscanf(line, "%s %d %d %d %h %s %d %d %d", t.name, t.len, t.cnt,
				t.ifg, t.seed, t.fault, t.faultFrame, t.good, t.bad) == 9)
				tests.push_back(t);  // Comment lines fail the scan
		end
		$fclose(fd);
	endtask

	// Monitor of the transmit port and the loopback with fault injection
	always @(negedge w_u0GMIIClk)
	begin
		if (!o_busy)
			idleGap = 1'b1;
		if (o_txEn && !prevEn)
		begin
			if (!idleGap)
				checkValue("gap length", curGap, lowRun);
			burstFrame = idleGap ? 0 : burstFrame + 1;
			idleGap    = 1'b0;
			highRun    = 0;
			txLfsr     = gmiiTrafficPkg::lfsrT'(curSeed);  // Payload restarts from the seed
			framesSeen++;
		end
		if (!o_txEn && prevEn)
		begin
			checkValue("frame length", curLen, highRun);
			lowRun = 0;
		end
		if (o_txEn)
			highRun++;
		else
			lowRun++;
		octetPos = highRun - 1;
		if (o_txEn)
		begin
			if (octetPos < 7)
				expD = 8'h55;  // Preamble
			else if (octetPos == 7)
				expD = 8'hD5;  // SFD
			else if (octetPos == 8)
				expD = gmiiTrafficPkg::octetT'(curLen);
			else if (octetPos == 9)
				expD = gmiiTrafficPkg::octetT'(curLen >> 8);
			else
			begin
				expD   = txLfsr;
				txLfsr = lfsrStep(txLfsr);
			end
			checkValue("tx octet", int'(expD), int'(o_txD));
		end
		if (o_doneStb)
		begin
			doneSeen++;
			checkValue("idle cycles before done", curGap + 1, lowRun);
			checkValue("busy at done", 0, int'(o_busy));
		end
		hit = o_txEn && faultKind != 0 && burstFrame == faultFrame && highRun - 1 == faultPos;
		i_rxD  <= (hit && faultKind == 1) ? ~o_txD : o_txD;
		i_rxDv <= o_txEn;
		i_rxEr <= hit && faultKind == 2;
		prevEn = o_txEn;
	end

	task automatic runTest(input testT t);
		int frames;
		int goodBefore;
		int badBefore;
		int framesBefore;
		int doneBefore;
		int lat;
		int waitCnt;
		frames       = (t.cnt == 0) ? 1 : t.cnt;
		curName      = t.name;
		curLen       = t.len;
		curGap       = (t.ifg > MinIfg) ? t.ifg : MinIfg;
		curSeed      = t.seed;
		faultKind    = (t.fault == "flip") ? 1 : (t.fault == "rxer") ? 2 : 0;
		faultFrame   = t.faultFrame;
		faultPos     = PayloadStart + int'($urandom % (t.len - PayloadStart));
		goodBefore   = int'(o_goodFrames);
		badBefore    = int'(o_badFrames);
		framesBefore = framesSeen;
		doneBefore   = doneSeen;
		i_frameLen   = gmiiTrafficPkg::frameLenT'(t.len);
		i_frameCnt   = gmiiTrafficPkg::frameCntT'(t.cnt);
		i_ifgLen     = gmiiTrafficPkg::ifgLenT'(t.ifg);
		i_seed       = gmiiTrafficPkg::lfsrT'(t.seed);
		i_startStb   = 1'b1;
		@(negedge w_u0GMIIClk);
		i_startStb = 1'b0;
		lat = 1;
		while (!o_txEn && lat < 100)
		begin
			@(negedge w_u0GMIIClk);
			lat++;
		end
		checkValue("start latency", StartLatency, lat);
		i_startStb = 1'b1;  // Busy now, so this one must be dropped
		@(negedge w_u0GMIIClk);
		i_startStb = 1'b0;
		waitCnt = 0;
		while (!o_doneStb && waitCnt < frames * (t.len + curGap) + 40)
		begin
			@(negedge w_u0GMIIClk);
			waitCnt++;
		end
		assert (o_doneStb)
		else
		begin
			errCount++;
			$display("Test %s never signalled the end of its burst", curName);
		end
		repeat (4) @(negedge w_u0GMIIClk);
		checkValue("frames sent", frames, framesSeen - framesBefore);
		checkValue("done strobes", 1, doneSeen - doneBefore);
		checkValue("good frames", t.good, int'(o_goodFrames) - goodBefore);
		checkValue("bad frames", t.bad, int'(o_badFrames) - badBefore);
	endtask

	initial
	begin
		wait (budgetReady);
		repeat (budget) @(posedge w_u0GMIIClk);
		$display("Timeout after %0d cycles, the tests did not complete", budget);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		int k;
		void'($urandom(9));
		i_reset    = 1'b1;
		i_startStb = 1'b0;
		i_frameLen = '0;
		i_frameCnt = '0;
		i_ifgLen   = '0;
		i_seed     = '0;
		loadTests();
		if (tests.size() == 0 && errCount == 0)
		begin
			errCount++;
			$display("The test file holds no tests");
		end
		budget = 40;
		for (k = 0; k < tests.size(); k++)
			budget += ((tests[k].cnt == 0) ? 1 : tests[k].cnt)
				* (tests[k].len + tests[k].ifg + MinIfg) + 100;
		budgetReady = 1'b1;
		repeat (16) @(negedge w_u0GMIIClk);
		i_reset = 1'b0;
		repeat (3) @(negedge w_u0GMIIClk);
		checkValue("txEn after reset", 0, int'(o_txEn));
		checkValue("txD after reset", 0, int'(o_txD));
		checkValue("busy after reset", 0, int'(o_busy));
		checkValue("done after reset", 0, int'(o_doneStb));
		checkValue("good count after reset", 0, int'(o_goodFrames));
		checkValue("bad count after reset", 0, int'(o_badFrames));
		for (k = 0; k < tests.size(); k++)
			runTest(tests[k]);
		k = gmiiTrafficTop_i.frameGen_i.txFramingChk_i.failCount;
		$display("Errors: %0d in checks, %0d in assertions", errCount, k);
		if (errCount + k == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- dv/gmiiTraffic_tests.txt
# name frameLen frameCnt ifgLen seed(hex) fault faultFrame expGood expBad
# fault: none, flip (one payload octet inverted) or rxer (rx error for one octet)
minFrame    64   1  12  01  none  0  1  0
burstRand   200  5  20  a7  none  0  5  0
shortIfg    97   4  3   3c  none  0  4  0
flipOne     150  6  14  5e  flip  2  5  1
rxErOne     80   3  12  c3  rxer  1  2  1
zeroSeed    120  2  40  00  none  0  2  0
zeroCount   64   0  12  11  none  0  1  0
flipLast    300  3  63  99  flip  2  2  1
rxErFirst   72   2  0   e4  rxer  0  1  1

//--- tb.f
common/gmiiTrafficPkg.sv
common/frameCfgIf.sv
src/pktCtrl.sv
frameGen/frameGen.sv
frameCheck/frameCheck.sv
src/gmiiTrafficTop.sv
dv/gmiiTraffic_assertions.sv
dv/gmiiTrafficTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -j 0
TOP       ?= gmiiTrafficTb
RTL_TOP   ?= gmiiTrafficTop
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o simv
	./$(OBJ_DIR)/simv +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
